// File: run_sim.sh
#!/usr/bin/env bash
# build the OPL register testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert -sv -f tb.f --top-module tb_opl_regs \
    -Mdir "$obj" -o tb_opl_regs
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$obj/tb_opl_regs" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

// File: src/opl_bus_pkg.sv
// OPL host bus types for register class opcodes and the decoded write request
package opl_bus_pkg;

    // which register byte a host write targets
    typedef enum logic [2:0] {
        NONE    = 3'd0,
        MULT    = 3'd1,
        KSL_TL  = 3'd2,
        AR_DR   = 3'd3,
        SL_RR   = 3'd4,
        FNUM_HI = 3'd5,
        FB_CON  = 3'd6
    } reg_class_t;

    // request held steady for one full slot rotation
    typedef struct packed {
        reg_class_t cls;
        // operator group or channel / 3
        logic [1:0] sel_group;
        // operator sub-slot or channel mod 3
        logic [2:0] sel_sub;
        // raw host data byte
        logic [7:0] data;
    } wr_req_t;

endpackage

// File: src/opl_cfg_pkg.sv
// OPL configuration types for operator and channel parameters and slot role
package opl_cfg_pkg;

    // operator parameters in register byte order, MSB byte first
    typedef struct packed {
        // byte 1 from 0x20 block
        logic       am;
        logic       vib;
        logic       en_sus;
        logic       ks;
        logic [3:0] mul;
        // byte 2 from 0x40 block
        logic [1:0] ksl;
        logic [5:0] tl;
        // byte 3 from 0x60 block
        logic [3:0] arate;
        logic [3:0] drate;
        // byte 4 from 0x80 block
        logic [3:0] sl;
        logic [3:0] rrate;
    } op_cfg_t;

    // per-channel parameters
    typedef struct packed {
        // 0xB0 block
        logic       keyon;
        logic [2:0] block;
        // low byte comes from 0xA0 latch
        logic [9:0] fnum;
        // 0xC0 block
        logic [2:0] fb;
        logic       con;
    } ch_cfg_t;

    // sub-slots 0..2 modulate and 3..5 carry
    typedef enum logic {
        MODULATOR = 1'b0,
        CARRIER   = 1'b1
    } slot_role_t;

endpackage

// File: src/opl_macros.svh
// OPL register section sizes for channel and slot counts and configuration word widths
`ifndef OPL_MACROS_SVH
`define OPL_MACROS_SVH

// two-operator channels
`define OPL_CH 9

// one modulator and one carrier per channel
`define OPL_SLOTS (2 * `OPL_CH)

// operator word is four register bytes
`define OPL_OPCFG_W 32

// keyon + block + fnum + fb + con
`define OPL_CHCFG_W 18

`endif

// File: src/opl_mmr.sv
// OPL host write decoder that turns address and data writes into a held register request
`timescale 1ns/1ps
`include "opl_macros.svh"

module opl_mmr (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wr,
    input  logic                 a0,
    input  logic [7:0]           din,
    input  logic                 cen,
    output opl_bus_pkg::wr_req_t req,
    output logic [7:0]           latch_fnum,
    output logic                 busy
);

    logic [7:0] addr;
    logic [4:0] cnt;
    logic [3:0] ch;
    logic       ch_ok;
    logic       op_ok;
    logic [1:0] ch_grp;
    logic [2:0] ch_sub;
    logic       dec_fnum_lo;
    opl_bus_pkg::wr_req_t dec;

    // operator offsets 0x00-05 0x08-0D 0x10-15
    assign op_ok = addr[4:3] != 2'd3 && addr[2:0] <= 3'd5;
    assign ch    = addr[3:0];
    assign ch_ok = ch < 4'(`OPL_CH);

    // channel to group and sub-slot
    always_comb begin
        if (ch >= 4'd6) begin
            ch_grp = 2'd2;
            ch_sub = 3'(ch - 4'd6);
        end else if (ch >= 4'd3) begin
            ch_grp = 2'd1;
            ch_sub = 3'(ch - 4'd3);
        end else begin
            ch_grp = 2'd0;
            ch_sub = ch[2:0];
        end
    end

    always_comb begin
        dec         = '0;
        dec.data    = din;
        dec_fnum_lo = 1'b0;
        case (addr[7:5])
            3'd1, 3'd2, 3'd3, 3'd4: begin
                if (op_ok) begin
                    // 0x20 0x40 0x60 0x80 map to consecutive classes
                    dec.cls       = opl_bus_pkg::reg_class_t'(addr[7:5]);
                    dec.sel_group = addr[4:3];
                    dec.sel_sub   = addr[2:0];
                end
            end
            3'd5: begin
                if (ch_ok && !addr[4]) begin
                    dec_fnum_lo = 1'b1;
                end else if (ch_ok) begin
                    dec.cls       = opl_bus_pkg::FNUM_HI;
                    dec.sel_group = ch_grp;
                    dec.sel_sub   = ch_sub;
                end
            end
            3'd6: begin
                if (ch_ok && !addr[4]) begin
                    dec.cls       = opl_bus_pkg::FB_CON;
                    dec.sel_group = ch_grp;
                    dec.sel_sub   = ch_sub;
                end
            end
            default: dec.cls = opl_bus_pkg::NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr       <= '0;
            latch_fnum <= '0;
            req        <= '0;
            busy       <= 1'b0;
            cnt        <= '0;
        end else begin
            if (wr && !a0) begin
                addr <= din;
            end
            // data writes while busy are lost
            if (wr && a0 && !busy) begin
                if (dec_fnum_lo) begin
                    latch_fnum <= din;
                end
                if (dec.cls != opl_bus_pkg::NONE) begin
                    req  <= dec;
                    busy <= 1'b1;
                    cnt  <= '0;
                end
            end else if (busy && cen) begin
                // retire after one full rotation
                if (cnt == 5'(2 * `OPL_CH - 1)) begin
                    req.cls <= opl_bus_pkg::NONE;
                    busy    <= 1'b0;
                    cnt     <= '0;
                end else begin
                    cnt <= cnt + 5'd1;
                end
            end
        end
    end

    a_busy_cls: assert property (@(posedge clk) disable iff (rst)
        busy == (req.cls != opl_bus_pkg::NONE));

endmodule

// File: src/opl_op_csr.sv
// operator configuration ring that circulates 18 slot words and patches one byte per match
`timescale 1ns/1ps
`include "opl_macros.svh"

module opl_op_csr (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic [7:0]              data,
    input  opl_bus_pkg::reg_class_t cls,
    input  logic                    upd_i,
    input  logic                    upd_ii,
    input  logic                    upd_iv,
    output opl_cfg_pkg::op_cfg_t    shift_out
);

    logic [`OPL_OPCFG_W-1:0] ring [`OPL_SLOTS];
    logic [`OPL_OPCFG_W-1:0] ring_in;
    opl_cfg_pkg::op_cfg_t    at_head;
    opl_cfg_pkg::op_cfg_t    at_ksl;
    opl_cfg_pkg::op_cfg_t    at_rate;
    opl_cfg_pkg::op_cfg_t    at_tail;
    logic hit_mult;
    logic hit_ksl_tl;
    logic hit_ar_dr;
    logic hit_sl_rr;

    // byte owner is the slot current at entry minus the flag delay
    assign hit_mult   = upd_i  && cls == opl_bus_pkg::MULT;
    assign hit_ar_dr  = upd_ii && cls == opl_bus_pkg::AR_DR;
    assign hit_sl_rr  = upd_ii && cls == opl_bus_pkg::SL_RR;
    assign hit_ksl_tl = upd_iv && cls == opl_bus_pkg::KSL_TL;

    // tail word re-enters with at most one byte swapped
    assign ring_in = {hit_mult   ? data : at_tail[31:24],
                      hit_ksl_tl ? data : at_tail[23:16],
                      hit_ar_dr  ? data : at_tail[15:8],
                      hit_sl_rr  ? data : at_tail[7:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `OPL_SLOTS; i++) begin
                ring[i] <= '0;
            end
        end else if (cen) begin
            ring[0] <= ring_in;
            for (int i = 1; i < `OPL_SLOTS; i++) begin
                ring[i] <= ring[i-1];
            end
        end
    end

    // taps picked so every field lands on its pipeline stage
    assign at_head = ring[0];
    assign at_ksl  = ring[`OPL_SLOTS-4];
    assign at_rate = ring[`OPL_SLOTS-2];
    assign at_tail = ring[`OPL_SLOTS-1];

    always_comb begin
        // am vib en_sus and tl straight off the tail
        shift_out       = at_tail;
        // ks and mul one slot behind
        shift_out.ks    = at_head.ks;
        shift_out.mul   = at_head.mul;
        shift_out.ksl   = at_ksl.ksl;
        shift_out.arate = at_rate.arate;
        shift_out.drate = at_rate.drate;
        shift_out.sl    = at_rate.sl;
        shift_out.rrate = at_rate.rrate;
    end

    // stage flags come from distinct slot delays so only one byte owner can match
    a_one_byte: assert property (@(posedge clk) disable iff (rst)
        cen |-> $onehot0({upd_i, upd_ii, upd_iv}));

endmodule

// File: src/opl_reg.sv
// OPL register block with slot sequencer, update matching, channel memory and operator store
`timescale 1ns/1ps
`include "opl_macros.svh"

module opl_reg (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  opl_bus_pkg::wr_req_t    req,
    input  logic [7:0]              latch_fnum,
    output logic                    zero,
    output logic [1:0]              group,
    output opl_cfg_pkg::slot_role_t role,
    output opl_cfg_pkg::op_cfg_t    op_cfg,
    output opl_cfg_pkg::ch_cfg_t    ch_cfg
);

    localparam int ch_per_group = 3;
    localparam int n_groups     = `OPL_CH / ch_per_group;
    localparam int n_subs       = `OPL_SLOTS / n_groups;

    typedef struct packed {
        logic [1:0] grp;
        logic [2:0] sub;
    } slot_pos_t;

    slot_pos_t pos;
    slot_pos_t pos_next;
    slot_pos_t pos_ii;
    slot_pos_t pos_iii;
    slot_pos_t pos_iv;
    slot_pos_t sel;
    logic upd_i;
    logic upd_ii;
    logic upd_iv;
    logic up_fnum;
    logic up_fbcon;
    opl_cfg_pkg::ch_cfg_t ch_new;
    logic [`OPL_CHCFG_W-1:0] ch_in  [n_groups];
    logic [`OPL_CHCFG_W-1:0] ch_out [n_groups];

    // sub-slot 0..5 then group 0..2
    always_comb begin
        pos_next = pos;
        if (pos.sub == 3'(n_subs - 1)) begin
            pos_next.sub = '0;
            pos_next.grp = (pos.grp == 2'(n_groups - 1)) ? 2'd0 : pos.grp + 2'd1;
        end else begin
            pos_next.sub = pos.sub + 3'd1;
        end
    end

    // delayed slot positions for stage II and IV compares
    always_ff @(posedge clk) begin
        if (rst) begin
            pos     <= '0;
            pos_ii  <= '{grp: 2'(n_groups - 1), sub: 3'(n_subs - 1)};
            pos_iii <= '{grp: 2'(n_groups - 1), sub: 3'(n_subs - 2)};
            pos_iv  <= '{grp: 2'(n_groups - 1), sub: 3'(n_subs - 3)};
        end else if (cen) begin
            pos     <= pos_next;
            pos_ii  <= pos;
            pos_iii <= pos_ii;
            pos_iv  <= pos_iii;
        end
    end

    assign group = pos.grp;
    assign zero  = pos == '0;
    assign role  = (pos.sub >= 3'(n_subs / 2)) ? opl_cfg_pkg::CARRIER : opl_cfg_pkg::MODULATOR;

    // request is steady for 18 cen so each stage sees its slot once
    assign sel    = '{grp: req.sel_group, sub: req.sel_sub};
    assign upd_i  = pos == sel;
    assign upd_ii = pos_ii == sel;
    assign upd_iv = pos_iv == sel;

    opl_op_csr u_op_csr (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .data      (req.data),
        .cls       (req.cls),
        .upd_i     (upd_i),
        .upd_ii    (upd_ii),
        .upd_iv    (upd_iv),
        .shift_out (op_cfg)
    );

    // channel writes only hit on sub-slots 0..2
    assign up_fnum  = upd_i && req.cls == opl_bus_pkg::FNUM_HI;
    assign up_fbcon = upd_i && req.cls == opl_bus_pkg::FB_CON;

    always_comb begin
        case (pos.grp)
            2'd1:    ch_cfg = ch_out[1];
            2'd2:    ch_cfg = ch_out[2];
            default: ch_cfg = ch_out[0];
        endcase
        ch_new = ch_cfg;
        if (up_fnum) begin
            ch_new.keyon = req.data[5];
            ch_new.block = req.data[4:2];
            ch_new.fnum  = {req.data[1:0], latch_fnum};
        end
        if (up_fbcon) begin
            ch_new.fb  = req.data[3:1];
            ch_new.con = req.data[0];
        end
    end

    // idle groups recirculate, 12 cen keeps their phase
    for (genvar g = 0; g < n_groups; g++) begin : g_ch_mem
        assign ch_in[g] = (pos.grp == 2'(g)) ? ch_new : ch_out[g];

        opl_sh_rst #(
            .width  (`OPL_CHCFG_W),
            .stages (ch_per_group)
        ) u_ch_mem (
            .clk  (clk),
            .rst  (rst),
            .cen  (cen),
            .din  (ch_in[g]),
            .drop (ch_out[g])
        );
    end

    a_sub_range: assert property (@(posedge clk) disable iff (rst)
        pos.sub <= 3'(n_subs - 1));

    a_group_range: assert property (@(posedge clk) disable iff (rst)
        pos.grp != 2'd3);

endmodule

// File: src/opl_regs_top.sv
// OPL register section top pairing the host write decoder with the register block
`timescale 1ns/1ps

module opl_regs_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic                    wr,
    input  logic                    a0,
    input  logic [7:0]              din,
    output logic                    busy,
    output logic                    zero,
    output logic [1:0]              group,
    output opl_cfg_pkg::slot_role_t role,
    output opl_cfg_pkg::op_cfg_t    op_cfg,
    output opl_cfg_pkg::ch_cfg_t    ch_cfg
);

    opl_bus_pkg::wr_req_t req;
    logic [7:0]           latch_fnum;

    // host side
    opl_mmr u_mmr (
        .clk        (clk),
        .rst        (rst),
        .wr         (wr),
        .a0         (a0),
        .din        (din),
        .cen        (cen),
        .req        (req),
        .latch_fnum (latch_fnum),
        .busy       (busy)
    );

    // slot pipeline side
    opl_reg u_reg (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .req        (req),
        .latch_fnum (latch_fnum),
        .zero       (zero),
        .group      (group),
        .role       (role),
        .op_cfg     (op_cfg),
        .ch_cfg     (ch_cfg)
    );

endmodule

// File: src/opl_sh_rst.sv
// multi-stage shift register with synchronous clear, advancing on clock enable
`timescale 1ns/1ps

module opl_sh_rst #(
    parameter int width  = 18,
    parameter int stages = 3
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  logic [width-1:0] din,
    output logic [width-1:0] drop
);

    logic [width-1:0] bits [stages];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < stages; i++) begin
                bits[i] <= '0;
            end
        end else if (cen) begin
            bits[0] <= din;
            // move everything one stage down
            for (int i = 1; i < stages; i++) begin
                bits[i] <= bits[i-1];
            end
        end
    end

    // oldest entry leaves here
    assign drop = bits[stages-1];

endmodule

// File: tb.f
+incdir+src
src/opl_cfg_pkg.sv
src/opl_bus_pkg.sv
src/opl_sh_rst.sv
src/opl_op_csr.sv
src/opl_reg.sv
src/opl_mmr.sv
src/opl_regs_top.sv
test/tb_opl_regs.sv

// File: test/tb_opl_regs.sv
// directed testbench for the OPL register section, checking the slot stream against a model
`timescale 1ns/1ps
`include "opl_macros.svh"

module tb_opl_regs;

    logic                    clk;
    logic                    rst;
    logic                    cen;
    logic                    wr;
    logic                    a0;
    logic [7:0]              din;
    logic                    busy;
    logic                    zero;
    logic [1:0]              group;
    opl_cfg_pkg::slot_role_t role;
    opl_cfg_pkg::op_cfg_t    op_cfg;
    opl_cfg_pkg::ch_cfg_t    ch_cfg;

    // reference copy of every register byte
    opl_cfg_pkg::op_cfg_t op_model [`OPL_SLOTS];
    opl_cfg_pkg::ch_cfg_t ch_model [`OPL_CH];
    logic [7:0]           fnum_lo;
    int                   errors;
    int                   checks;
    integer               seed;

    opl_regs_top UUT (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .wr     (wr),
        .a0     (a0),
        .din    (din),
        .busy   (busy),
        .zero   (zero),
        .group  (group),
        .role   (role),
        .op_cfg (op_cfg),
        .ch_cfg (ch_cfg)
    );

    always #2 clk = ~clk;

    // slot clock enable on every second clock
    always @(posedge clk) begin
        #1;
        cen = ~cen;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] seen);
        checks++;
        assert (seen === expected)
        else begin
            errors++;
            $display("[FAIL] %0t ns %s expected %0h seen %0h", $time, name, expected, seen);
        end
    endtask

    task automatic check_waited(input string what, input logic done);
        checks++;
        assert (done)
        else begin
            errors++;
            $display("[FAIL] %0t ns gave up waiting for %s", $time, what);
        end
    endtask

    // host view of the register map, true when the write starts a request
    function automatic logic model_write(input logic [7:0] addr, input logic [7:0] data);
        int   off;
        int   s;
        int   ch;
        logic hit;
        off = int'(addr[4:0]);
        ch  = int'(addr[3:0]);
        hit = 1'b0;
        if (addr[7:5] >= 3'd1 && addr[7:5] <= 3'd4 && off / 8 < 3 && off % 8 < 6) begin
            // group is offset / 8, sub-slot offset mod 8
            s   = (off / 8) * 6 + off % 8;
            hit = 1'b1;
            case (addr[7:5])
                3'd1:    op_model[s][31:24] = data;
                3'd2:    op_model[s][23:16] = data;
                3'd3:    op_model[s][15:8]  = data;
                default: op_model[s][7:0]   = data;
            endcase
        end else if (addr[7:4] == 4'hA && ch < `OPL_CH) begin
            fnum_lo = data;
        end else if (addr[7:4] == 4'hB && ch < `OPL_CH) begin
            hit                = 1'b1;
            ch_model[ch].keyon = data[5];
            ch_model[ch].block = data[4:2];
            ch_model[ch].fnum  = {data[1:0], fnum_lo};
        end else if (addr[7:4] == 4'hC && ch < `OPL_CH) begin
            hit              = 1'b1;
            ch_model[ch].fb  = data[3:1];
            ch_model[ch].con = data[0];
        end
        return hit;
    endfunction

    // one clock write strobe, entered and left just after a rising edge
    task automatic bus_strobe(input logic sel_data, input logic [7:0] value);
        wr  = 1'b1;
        a0  = sel_data;
        din = value;
        @(posedge clk);
        #1;
        wr  = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy !== 1'b0 && n < 100) begin
            @(posedge clk);
            #1;
            n++;
        end
        check_waited("busy to fall", busy === 1'b0);
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        logic is_req;
        @(posedge clk);
        #1;
        bus_strobe(1'b0, addr);
        bus_strobe(1'b1, data);
        is_req = model_write(addr, data);
        check_value($sformatf("busy after write to %02h", addr), 32'(is_req), 32'(busy));
        wait_idle();
    endtask

    // sample point is a falling edge while cen is high
    task automatic wait_cen_slot();
        int n;
        n = 0;
        @(negedge clk);
        while (cen !== 1'b1 && n < 8) begin
            @(negedge clk);
            n++;
        end
        check_waited("cen to rise", cen === 1'b1);
    endtask

    task automatic check_stream();
        int n;
        int p;
        opl_cfg_pkg::op_cfg_t want;
        n = 0;
        wait_cen_slot();
        while (zero !== 1'b1 && n < 40) begin
            wait_cen_slot();
            n++;
        end
        check_waited("zero to rise", zero === 1'b1);
        // one extra slot to see zero come round again
        for (int k = 0; k <= `OPL_SLOTS; k++) begin
            if (k > 0) begin
                wait_cen_slot();
            end
            p    = k % `OPL_SLOTS;
            want = op_model[p];
            // ks and mul lag one slot, tl three
            want.ks  = op_model[(p + `OPL_SLOTS - 1) % `OPL_SLOTS].ks;
            want.mul = op_model[(p + `OPL_SLOTS - 1) % `OPL_SLOTS].mul;
            want.tl  = op_model[(p + `OPL_SLOTS - 3) % `OPL_SLOTS].tl;
            check_value($sformatf("zero slot %0d", p), 32'(p == 0), 32'(zero));
            check_value($sformatf("group slot %0d", p), 32'(p / 6), 32'(group));
            check_value($sformatf("role slot %0d", p), 32'(p % 6 >= 3), 32'(role));
            check_value($sformatf("op_cfg slot %0d", p), 32'(want), 32'(op_cfg));
            check_value($sformatf("ch_cfg slot %0d", p), 32'(ch_model[(p / 6) * 3 + p % 6 % 3]),
                        32'(ch_cfg));
        end
    endtask

    task automatic test_reset_state();
        check_value("busy after reset", 32'(1'b0), 32'(busy));
        check_stream();
    endtask

    // every byte class at every valid offset
    task automatic test_operator_regs();
        logic [7:0] base;
        for (int b = 1; b <= 4; b++) begin
            base = 8'(b * 32);
            for (int g = 0; g < 3; g++) begin
                for (int s = 0; s < 6; s++) begin
                    write_reg(base + 8'(g * 8 + s), 8'($random(seed)));
                    check_stream();
                end
            end
        end
    endtask

    task automatic test_channel_fnum();
        for (int ch = 0; ch < `OPL_CH; ch++) begin
            write_reg(8'hA0 + 8'(ch), 8'($random(seed)));
            write_reg(8'hB0 + 8'(ch), 8'($random(seed)));
            check_stream();
        end
        // low byte alone stays in the decoder latch
        write_reg(8'hA4, 8'($random(seed)));
        check_stream();
    endtask

    task automatic test_channel_fbcon();
        for (int ch = 0; ch < `OPL_CH; ch++) begin
            write_reg(8'hC0 + 8'(ch), 8'($random(seed)));
            check_stream();
        end
    endtask

    task automatic test_dropped_writes();
        logic [7:0] bad_addr [10];
        bad_addr = '{8'h26, 8'h2E, 8'h36, 8'h5F, 8'h9D, 8'hA9, 8'hB9, 8'hC9, 8'hD2, 8'hF4};
        @(posedge clk);
        #1;
        bus_strobe(1'b0, 8'h2B);
        bus_strobe(1'b1, 8'h5A);
        void'(model_write(8'h2B, 8'h5A));
        check_value("busy after first write", 32'(1'b1), 32'(busy));
        // second data write lands while busy, never reaches the model
        bus_strobe(1'b1, 8'hA5);
        wait_idle();
        check_stream();
        foreach (bad_addr[i]) begin
            write_reg(bad_addr[i], 8'($random(seed)));
        end
        check_stream();
    endtask

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        cen     = 1'b0;
        wr      = 1'b0;
        a0      = 1'b0;
        din     = 8'h00;
        errors  = 0;
        checks  = 0;
        seed    = 32'hce3;
        fnum_lo = 8'h00;
        foreach (op_model[i]) begin
            op_model[i] = '0;
        end
        foreach (ch_model[i]) begin
            ch_model[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_operator_regs();
        test_channel_fnum();
        test_channel_fbcon();
        test_dropped_writes();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
